/* compile.f */
verilog/bank_htu_pkg.sv
verilog/bank_htu_offset.sv
verilog/bank_htu_cacheline.sv
verilog/bank_htu_set.sv
verilog/bank_htu.sv
test/tb_clock.sv
test/tb_bank_htu.sv

/* run.sh */
#!/bin/sh
# Build and run the bank_htu testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_bank_htu -f compile.f -Mdir obj_dir -o sim

./obj_dir/sim > sim.log 2>&1
cat sim.log

if grep -q "Test FAILED" sim.log; then
  exit 1
fi
exit 0

/* test/tb_bank_htu.sv */
module tb_bank_htu import bank_htu_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_WAYS    = 2;
  localparam int NUM_CMDS    = 2000;
  localparam int ACK_TIMEOUT = 20;
  localparam int RST_TIMEOUT = 50;

  logic        clk;
  logic        rst;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [31:0] wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic        wb_ack;

  int errors    = 0;
  int cmd_count = 0;
  logic timed_out = 1'b0;

  // Reference model, one entry per set and way.
  logic        m_valid [16][NUM_WAYS];
  tag_t        m_tag   [16][NUM_WAYS];
  offs_state_t m_st    [16][NUM_WAYS][2];
  int          m_rr    [16];

  // Six tags over two ways per set keep the sets under pressure.
  tag_t tag_pool [6] = '{22'h00_0001, 22'h15_5aa0, 22'h3f_ffff,
                         22'h00_1234, 22'h2a_0c0c, 22'h10_0000};

  tb_clock clock_gen (.clk_o(clk), .rst_o(rst));

  bank_htu #(.NUM_WAYS(NUM_WAYS)) dut (
    .clk_i   (clk     ),
    .rst_i   (rst     ),
    .wb_cyc_i(wb_cyc  ),
    .wb_stb_i(wb_stb  ),
    .wb_we_i (wb_we   ),
    .wb_adr_i(wb_adr  ),
    .wb_dat_i(wb_dat_w),
    .wb_dat_o(wb_dat_r),
    .wb_ack_o(wb_ack  )
  );

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  // Called on a falling edge; holds the strobe through the ack cycle.
  task automatic bus_transfer(input logic we, input logic [31:0] adr,
                              input logic [31:0] dat, output logic [31:0] rdata);
    int cnt;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = dat;
    cnt      = 0;
    @(negedge clk);
    while (!wb_ack && cnt < ACK_TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    rdata = wb_dat_r;
    if (!wb_ack) begin
      errors++;
      timed_out = 1'b1;
      $display("ERROR: no acknowledge from the DUT within %0d cycles", ACK_TIMEOUT);
    end
    else begin
      if (cnt != 0) begin
        errors++;
        $display("ERROR: acknowledge came %0d cycles late", cnt);
      end
      @(negedge clk); // Ack is taken on the rising edge before.
      if (wb_ack) begin
        errors++;
        $display("ERROR: acknowledge held for more than one cycle");
      end
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic apply_model(input logic [31:0] adr, input htu_op_t op,
                             output logic [31:0] exp);
    tag_t tag;
    int   s;
    int   off;
    int   hw;
    int   vw;
    tag = adr[31:10];
    s   = int'(adr[9:6]);
    off = int'(adr[5]);
    exp = '0;
    hw  = -1;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (m_valid[s][w] && m_tag[s][w] == tag) hw = w;
    end
    if (hw >= 0) begin
      case (op)
        OP_READ: if (m_st[s][hw][off] == OFFS_INVALID) m_st[s][hw][off] = OFFS_CLEAN;
        OP_WRITE: m_st[s][hw][off] = OFFS_DIRTY;
        OP_FLUSH: begin
          for (int o = 0; o < 2; o++) begin
            if (m_st[s][hw][o] == OFFS_DIRTY) m_st[s][hw][o] = OFFS_CLEAN;
          end
        end
        default: begin
          m_valid[s][hw] = 1'b0;
          m_st[s][hw][0] = OFFS_INVALID;
          m_st[s][hw][1] = OFFS_INVALID;
        end
      endcase
      exp[RES_HIT]                   = 1'b1;
      exp[RES_WAY_HI:RES_WAY_LO]     = 2'(hw);
      exp[RES_OFFS0_HI:RES_OFFS0_LO] = m_st[s][hw][0];
      exp[RES_OFFS1_HI:RES_OFFS1_LO] = m_st[s][hw][1];
    end
    else if (op == OP_READ || op == OP_WRITE) begin
      vw = -1;
      for (int w = NUM_WAYS - 1; w >= 0; w--) begin
        if (!m_valid[s][w]) vw = w;
      end
      if (vw < 0) begin // Full set.
        vw      = m_rr[s];
        m_rr[s] = (m_rr[s] + 1) % NUM_WAYS;
      end
      exp[RES_VICTIM_DIRTY] = m_valid[s][vw] &&
               (m_st[s][vw][0] == OFFS_DIRTY || m_st[s][vw][1] == OFFS_DIRTY);
      m_valid[s][vw]    = 1'b1;
      m_tag[s][vw]      = tag;
      m_st[s][vw][off]  = (op == OP_WRITE) ? OFFS_DIRTY : OFFS_CLEAN;
      m_st[s][vw][1-off] = OFFS_INVALID;
      exp[RES_WAY_HI:RES_WAY_LO]     = 2'(vw);
      exp[RES_ALLOC]                 = 1'b1;
      exp[RES_OFFS0_HI:RES_OFFS0_LO] = m_st[s][vw][0];
      exp[RES_OFFS1_HI:RES_OFFS1_LO] = m_st[s][vw][1];
    end
  endtask

  task automatic compare_result(input logic [31:0] got, input logic [31:0] exp);
    check_value("wb_dat_o.hit", 32'(got[RES_HIT]), 32'(exp[RES_HIT]));
    check_value("wb_dat_o.way", 32'(got[RES_WAY_HI:RES_WAY_LO]),
                32'(exp[RES_WAY_HI:RES_WAY_LO]));
    check_value("wb_dat_o.alloc", 32'(got[RES_ALLOC]), 32'(exp[RES_ALLOC]));
    check_value("wb_dat_o.victim_dirty", 32'(got[RES_VICTIM_DIRTY]),
                32'(exp[RES_VICTIM_DIRTY]));
    check_value("wb_dat_o.offs0", 32'(got[RES_OFFS0_HI:RES_OFFS0_LO]),
                32'(exp[RES_OFFS0_HI:RES_OFFS0_LO]));
    check_value("wb_dat_o.offs1", 32'(got[RES_OFFS1_HI:RES_OFFS1_LO]),
                32'(exp[RES_OFFS1_HI:RES_OFFS1_LO]));
    check_value("wb_dat_o.unused", 32'(got[31:RES_OFFS1_HI+1]), 32'h0);
  endtask

  // Command write, then result read.
  task automatic run_command(input logic [31:0] adr, input htu_op_t op,
                             output logic [31:0] got);
    logic [31:0] dat;
    logic [31:0] unused;
    logic [31:0] exp;
    dat      = $urandom();
    dat[1:0] = op;
    got      = '0;
    bus_transfer(1'b1, adr, dat, unused);
    if (!timed_out) bus_transfer(1'b0, $urandom(), 32'h0, got);
    apply_model(adr, op, exp);
    if (!timed_out) compare_result(got, exp);
    cmd_count++;
  endtask

  function automatic logic [31:0] make_addr(input tag_t tag, input logic [3:0] set,
                                            input logic off);
    return {tag, set, off, 5'h0};
  endfunction

  task automatic directed_sequence();
    logic [31:0] got;
    run_command(make_addr(tag_pool[0], 4'd3, 1'b0), OP_READ, got);
    check_value("wb_dat_o.alloc", 32'(got[RES_ALLOC]), 32'd1);
    check_value("wb_dat_o.way", 32'(got[RES_WAY_HI:RES_WAY_LO]), 32'd0);
    check_value("wb_dat_o.offs0", 32'(got[RES_OFFS0_HI:RES_OFFS0_LO]), 32'(OFFS_CLEAN));
    run_command(make_addr(tag_pool[0], 4'd3, 1'b1), OP_WRITE, got);
    run_command(make_addr(tag_pool[1], 4'd3, 1'b0), OP_READ, got);
    run_command(make_addr(tag_pool[2], 4'd3, 1'b1), OP_READ, got);
    check_value("wb_dat_o.victim_dirty", 32'(got[RES_VICTIM_DIRTY]), 32'd1); // Way 0 was dirty.
    run_command(make_addr(tag_pool[1], 4'd3, 1'b1), OP_WRITE, got);
    run_command(make_addr(tag_pool[1], 4'd3, 1'b0), OP_FLUSH, got);
    check_value("wb_dat_o.offs1", 32'(got[RES_OFFS1_HI:RES_OFFS1_LO]), 32'(OFFS_CLEAN));
    run_command(make_addr(tag_pool[2], 4'd3, 1'b0), OP_INVALIDATE, got);
    run_command(make_addr(tag_pool[2], 4'd3, 1'b0), OP_READ, got);
    check_value("wb_dat_o.hit", 32'(got[RES_HIT]), 32'd0);
    run_command(make_addr(tag_pool[0], 4'd3, 1'b0), OP_FLUSH, got);
    check_value("wb_dat_o.alloc", 32'(got[RES_ALLOC]), 32'd0);
    run_command(make_addr(tag_pool[0], 4'd3, 1'b1), OP_INVALIDATE, got);
  endtask

  task automatic random_command();
    logic [31:0] r;
    logic [31:0] got;
    int          idx;
    r   = $urandom();
    idx = int'(r[7:0]) % 6;
    run_command({tag_pool[idx], r[11:8], r[12], r[17:13]}, htu_op_t'(r[19:18]), got);
  endtask

  initial begin
    int          cnt;
    logic [31:0] rd;
    void'($urandom(32'hb03f_2c2c));
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    for (int s = 0; s < 16; s++) begin
      m_rr[s] = 0;
      for (int w = 0; w < NUM_WAYS; w++) begin
        m_valid[s][w] = 1'b0;
        m_tag[s][w]   = '0;
        m_st[s][w][0] = OFFS_INVALID;
        m_st[s][w][1] = OFFS_INVALID;
      end
    end
    cnt = 0;
    @(negedge clk);
    while (rst && cnt < RST_TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (rst) begin
      errors++;
      timed_out = 1'b1;
      $display("ERROR: reset was never released");
    end
    if (!timed_out) begin
      bus_transfer(1'b0, 32'h0, 32'h0, rd);
      check_value("wb_dat_o", rd, 32'h0); // Result register after reset.
      directed_sequence();
    end
    for (int i = 0; i < NUM_CMDS && !timed_out; i++) begin
      random_command();
    end
    $display("Done: %0d commands, %0d errors", cmd_count, errors);
    if (errors == 0) begin
      $display("Test OK");
    end
    else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* test/tb_clock.sv */
module tb_clock #(
  parameter int PERIOD_NS  = 100,
  parameter int RST_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_o
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0; // Released away from the active edge.
  end

endmodule

/* verilog/bank_htu.sv */
module bank_htu import bank_htu_pkg::*; #(
  parameter int NUM_WAYS = 2
) (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  logic [31:0] wb_adr_i,
  input  logic [31:0] wb_dat_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack_o
);

  htu_op_t             op;
  tag_t                access_tag;
  set_idx_t            set_idx;
  logic                access_offset1;
  logic                cmd_req;
  logic                cmd_valid;
  logic                op_is_read;
  logic                op_is_write;
  logic                op_is_flush;
  logic                op_is_invalidate;
  logic                ack_q;
  logic [31:0]         result_d;
  logic [31:0]         result_q;
  logic [NUM_SETS-1:0] set_sel;
  logic [NUM_SETS-1:0] set_hit;
  logic [NUM_SETS-1:0] set_alloc;
  logic [NUM_SETS-1:0] set_vdirty;
  way_t                set_way   [NUM_SETS];
  offs_state_t         set_offs0 [NUM_SETS];
  offs_state_t         set_offs1 [NUM_SETS];

  assign access_tag     = wb_adr_i[31:ADR_TAG_LO];
  assign set_idx        = wb_adr_i[ADR_TAG_LO-1:ADR_SET_LO];
  assign access_offset1 = wb_adr_i[ADR_OFFS_BIT];

  assign op               = htu_op_t'(wb_dat_i[1:0]);
  assign op_is_read       = (op == OP_READ);
  assign op_is_write      = (op == OP_WRITE);
  assign op_is_flush      = (op == OP_FLUSH);
  assign op_is_invalidate = (op == OP_INVALIDATE);

  assign cmd_req   = wb_cyc_i & wb_stb_i & ~ack_q; // New request only.
  assign cmd_valid = cmd_req & wb_we_i;

  for (genvar s = 0; s < NUM_SETS; s++) begin : g_set
    assign set_sel[s] = cmd_valid & (set_idx == set_idx_t'(s));

    bank_htu_set #(
      .NUM_WAYS(NUM_WAYS)
    ) u_set (
      .clk_i             (clk_i           ),
      .rst_i             (rst_i           ),
      .set_sel_i         (set_sel[s]      ),
      .op_is_read_i      (op_is_read      ),
      .op_is_write_i     (op_is_write     ),
      .op_is_flush_i     (op_is_flush     ),
      .op_is_invalidate_i(op_is_invalidate),
      .access_offset1_i  (access_offset1  ),
      .access_tag_i      (access_tag      ),
      .set_hit_o         (set_hit[s]      ),
      .set_alloc_o       (set_alloc[s]    ),
      .victim_dirty_o    (set_vdirty[s]   ),
      .set_way_o         (set_way[s]      ),
      .offs0_next_o      (set_offs0[s]    ),
      .offs1_next_o      (set_offs1[s]    )
    );
  end

  always_comb begin
    result_d                                = '0;
    result_d[RES_HIT]                       = set_hit[set_idx];
    result_d[RES_WAY_HI:RES_WAY_LO]         = set_way[set_idx];
    result_d[RES_ALLOC]                     = set_alloc[set_idx];
    result_d[RES_VICTIM_DIRTY]              = set_vdirty[set_idx];
    result_d[RES_OFFS0_HI:RES_OFFS0_LO]     = set_offs0[set_idx];
    result_d[RES_OFFS1_HI:RES_OFFS1_LO]     = set_offs1[set_idx];
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      ack_q    <= 1'b0;
      result_q <= '0;
    end
    else begin
      ack_q <= cmd_req;
      if (cmd_valid) begin
        result_q <= result_d; // Same edge as the tag update.
      end
    end
  end

  assign wb_ack_o = ack_q;
  assign wb_dat_o = result_q;

  // The master holds the strobe until the ack is taken.
  a_ack_in_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
    wb_ack_o |-> (wb_cyc_i && wb_stb_i));

endmodule

/* verilog/bank_htu_set.sv */
module bank_htu_set import bank_htu_pkg::*; #(
  parameter int NUM_WAYS = 2
) (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        set_sel_i,
  input  logic        op_is_read_i,
  input  logic        op_is_write_i,
  input  logic        op_is_flush_i,
  input  logic        op_is_invalidate_i,
  input  logic        access_offset1_i,
  input  tag_t        access_tag_i,
  output logic        set_hit_o,
  output logic        set_alloc_o,
  output logic        victim_dirty_o,
  output way_t        set_way_o,
  output offs_state_t offs0_next_o,
  output offs_state_t offs1_next_o
);

  logic [NUM_WAYS-1:0] way_valid;
  logic [NUM_WAYS-1:0] way_hit;
  logic [NUM_WAYS-1:0] way_dirty;
  logic [NUM_WAYS-1:0] way_alloc;
  offs_state_t         way_offs0_next [NUM_WAYS];
  offs_state_t         way_offs1_next [NUM_WAYS];
  way_t                hit_way;
  way_t                victim_way;
  way_t                sel_way;
  way_t                rr_ptr_q;
  logic                any_invalid;
  logic                need_alloc;

  for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
    bank_htu_cacheline u_line (
      .clk_i               (clk_i              ),
      .rst_i               (rst_i              ),
      .set_hit_WV_i        (set_sel_i          ),
      .op_is_read_i        (op_is_read_i       ),
      .op_is_write_i       (op_is_write_i      ),
      .op_is_flush_i       (op_is_flush_i      ),
      .op_is_invalidate_i  (op_is_invalidate_i ),
      .access_offset1_i    (access_offset1_i   ),
      .cacheline_allocate_i(way_alloc[w]       ),
      .access_tag_i        (access_tag_i       ),
      .cacheline_valid_o   (way_valid[w]       ),
      .cacheline_hit_o     (way_hit[w]         ),
      .cacheline_dirty_o   (way_dirty[w]       ),
      .offset0_state_o     (                   ),
      .offset1_state_o     (                   ),
      .offset0_next_o      (way_offs0_next[w]  ),
      .offset1_next_o      (way_offs1_next[w]  )
    );
  end

  assign set_hit_o  = |way_hit;
  assign need_alloc = (op_is_read_i | op_is_write_i) & ~set_hit_o;
  assign sel_way    = set_hit_o ? hit_way : victim_way;

  always_comb begin
    hit_way = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (way_hit[w]) begin
        hit_way = way_t'(w);
      end
    end
  end

  // Lowest invalid way first, round-robin when the set is full.
  always_comb begin
    victim_way  = rr_ptr_q;
    any_invalid = 1'b0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (!way_valid[w]) begin
        victim_way  = way_t'(w);
        any_invalid = 1'b1;
      end
    end
  end

  always_comb begin
    way_alloc = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      way_alloc[w] = need_alloc & (victim_way == way_t'(w));
    end
  end

  // Flush or invalidate miss reports no line.
  always_comb begin
    victim_dirty_o = 1'b0;
    offs0_next_o   = OFFS_INVALID;
    offs1_next_o   = OFFS_INVALID;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if ((set_hit_o || need_alloc) && (sel_way == way_t'(w))) begin
        victim_dirty_o = need_alloc & way_valid[w] & way_dirty[w];
        offs0_next_o   = way_offs0_next[w];
        offs1_next_o   = way_offs1_next[w];
      end
    end
  end

  assign set_alloc_o = need_alloc;
  assign set_way_o   = (set_hit_o | need_alloc) ? sel_way : '0;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      rr_ptr_q <= '0;
    end
    else if (set_sel_i && need_alloc && !any_invalid) begin
      if (rr_ptr_q == way_t'(NUM_WAYS - 1)) begin
        rr_ptr_q <= '0;
      end
      else begin
        rr_ptr_q <= rr_ptr_q + 1'b1;
      end
    end
  end

  // A tag is never held by two ways of one set.
  a_onehot_hit: assert property (@(posedge clk_i) disable iff (rst_i)
    set_sel_i |-> $onehot0(way_hit));

endmodule

/* verilog/bank_htu_cacheline.sv */
module bank_htu_cacheline import bank_htu_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        set_hit_WV_i,
  input  logic        op_is_read_i,
  input  logic        op_is_write_i,
  input  logic        op_is_flush_i,
  input  logic        op_is_invalidate_i,
  input  logic        access_offset1_i,
  input  logic        cacheline_allocate_i,
  input  tag_t        access_tag_i,
  output logic        cacheline_valid_o,
  output logic        cacheline_hit_o,
  output logic        cacheline_dirty_o,
  output offs_state_t offset0_state_o,
  output offs_state_t offset1_state_o,
  output offs_state_t offset0_next_o,
  output offs_state_t offset1_next_o
);

  logic valid_q;
  tag_t tag_q;
  logic cacheline_hit_WV;
  logic cacheline_allocate_WV;

  assign cacheline_valid_o = valid_q;
  assign cacheline_hit_o   = valid_q & (access_tag_i == tag_q);
  assign cacheline_dirty_o = (offset0_state_o == OFFS_DIRTY) | (offset1_state_o == OFFS_DIRTY);

  // Qualified by the set select.
  assign cacheline_hit_WV      = set_hit_WV_i & cacheline_hit_o;
  assign cacheline_allocate_WV = set_hit_WV_i & cacheline_allocate_i;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end
    else if (cacheline_allocate_WV) begin
      valid_q <= 1'b1;
    end
    else if (cacheline_hit_WV && op_is_invalidate_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cacheline_allocate_WV) begin
      tag_q <= access_tag_i;
    end
  end

  bank_htu_offset offset0 (
    .clk_i               (clk_i                ),
    .rst_i               (rst_i                ),
    .offset_hit_i        (~access_offset1_i    ),
    .op_is_read_i        (op_is_read_i         ),
    .op_is_write_i       (op_is_write_i        ),
    .op_is_flush_i       (op_is_flush_i        ),
    .op_is_invalidate_i  (op_is_invalidate_i   ),
    .cacheline_hit_i     (cacheline_hit_WV     ),
    .cacheline_allocate_i(cacheline_allocate_WV),
    .offset_status_o     (offset0_state_o      ),
    .offset_next_o       (offset0_next_o       )
  );

  bank_htu_offset offset1 (
    .clk_i               (clk_i                ),
    .rst_i               (rst_i                ),
    .offset_hit_i        (access_offset1_i     ),
    .op_is_read_i        (op_is_read_i         ),
    .op_is_write_i       (op_is_write_i        ),
    .op_is_flush_i       (op_is_flush_i        ),
    .op_is_invalidate_i  (op_is_invalidate_i   ),
    .cacheline_hit_i     (cacheline_hit_WV     ),
    .cacheline_allocate_i(cacheline_allocate_WV),
    .offset_status_o     (offset1_state_o      ),
    .offset_next_o       (offset1_next_o       )
  );

endmodule

/* verilog/bank_htu_offset.sv */
module bank_htu_offset import bank_htu_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        offset_hit_i,
  input  logic        op_is_read_i,
  input  logic        op_is_write_i,
  input  logic        op_is_flush_i,
  input  logic        op_is_invalidate_i,
  input  logic        cacheline_hit_i,
  input  logic        cacheline_allocate_i,
  output offs_state_t offset_status_o,
  output offs_state_t offset_next_o
);

  offs_state_t state_q;

  assign offset_status_o = state_q;

  always_comb begin
    offset_next_o = state_q;
    if (cacheline_allocate_i) begin
      // Fresh line, only the accessed half holds data.
      if (!offset_hit_i) begin
        offset_next_o = OFFS_INVALID;
      end
      else if (op_is_write_i) begin
        offset_next_o = OFFS_DIRTY;
      end
      else if (op_is_read_i) begin
        offset_next_o = OFFS_CLEAN;
      end
    end
    else if (cacheline_hit_i) begin
      if (op_is_invalidate_i) begin
        offset_next_o = OFFS_INVALID;
      end
      else if (op_is_flush_i) begin
        if (state_q == OFFS_DIRTY) begin
          offset_next_o = OFFS_CLEAN; // Written back.
        end
      end
      else if (offset_hit_i && op_is_write_i) begin
        offset_next_o = OFFS_DIRTY;
      end
      else if (offset_hit_i && op_is_read_i && (state_q == OFFS_INVALID)) begin
        offset_next_o = OFFS_CLEAN;
      end
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= OFFS_INVALID;
    end
    else begin
      state_q <= offset_next_o;
    end
  end

  // The set only allocates into a way that missed.
  a_no_alloc_on_hit: assert property (@(posedge clk_i) disable iff (rst_i)
    !(cacheline_hit_i && cacheline_allocate_i));

endmodule

/* verilog/bank_htu_pkg.sv */
package bank_htu_pkg;

  // Address split.
  localparam int ADR_TAG_LO   = 10;
  localparam int ADR_SET_LO   = 6;
  localparam int ADR_OFFS_BIT = 5;

  localparam int TAG_W    = 32 - ADR_TAG_LO;
  localparam int SET_W    = ADR_TAG_LO - ADR_SET_LO;
  localparam int NUM_SETS = 16;

  typedef logic [TAG_W-1:0] tag_t;
  typedef logic [SET_W-1:0] set_idx_t;
  typedef logic [1:0]       way_t;     // Up to 4 ways.

  // State of one 32-byte half of a line.
  typedef enum logic [1:0] {
    OFFS_INVALID = 2'd0,
    OFFS_CLEAN   = 2'd1,
    OFFS_DIRTY   = 2'd2
  } offs_state_t;

  // Command code in wb_dat_i[1:0].
  typedef enum logic [1:0] {
    OP_READ       = 2'd0,
    OP_WRITE      = 2'd1,
    OP_FLUSH      = 2'd2,
    OP_INVALIDATE = 2'd3
  } htu_op_t;

  // Result register layout.
  localparam int RES_HIT          = 0;
  localparam int RES_WAY_LO       = 1;
  localparam int RES_WAY_HI       = 2;
  localparam int RES_ALLOC        = 3;
  localparam int RES_VICTIM_DIRTY = 4;
  localparam int RES_OFFS0_LO     = 5;
  localparam int RES_OFFS0_HI     = 6;
  localparam int RES_OFFS1_LO     = 7;
  localparam int RES_OFFS1_HI     = 8;

endpackage
